//--- design/channel_acq_defines.svh
`ifndef CHANNEL_ACQ_DEFINES_SVH
`define CHANNEL_ACQ_DEFINES_SVH

// data memory geometry
`define ACQ_ADDR_W      12          // 4096 words of two samples each
`define ACQ_LEN_W       13          // buffer_size and post_trig_size, up to 4096
`define ACQ_DATA_W      32          // memory, header and readout word

// raw ADC samples
`define ADC_SAMPLE_W    13          // one sample, over-range in the lsb
`define ADC_PAIR_W      26          // two samples per clock

// event header
`define HDR_WORDS       4           // words per event header
`define HDR_FIFO_DEPTH  16          // four events deep
`define HDR_MARKER      16'hadc0    // upper half of header word 0

`endif

//--- design/channel_acq_pkg.sv
package channel_acq_pkg;

  // acquisition controller states
  typedef enum logic [1:0] {
    ACQ_IDLE      = 2'd0,  // waiting for arm
    ACQ_ARMED     = 2'd1,  // writing the ring, waiting for trig
    ACQ_POST_TRIG = 2'd2,  // counting down post-trigger words
    ACQ_DONE      = 2'd3   // event captured, holding until arm drops
  } acq_state_t;

  // readout sequencer states
  typedef enum logic [1:0] {
    RD_IDLE   = 2'd0,
    RD_HEADER = 2'd1,      // header words coming out of the FIFO
    RD_DATA   = 2'd2       // walking the data memory
  } rd_state_t;

  // order of the words in one event header
  typedef enum logic [1:0] {
    HDR_ID         = 2'd0, // marker and channel number
    HDR_TRIG_NUM   = 2'd1,
    HDR_START_ADDR = 2'd2, // oldest word in the ring
    HDR_SIZE       = 2'd3  // ring length in words
  } hdr_word_t;

endpackage

//--- design/buffer_rd_if.sv
`timescale 1ns/1ps
`include "channel_acq_defines.svh"

// read side of the data memory and the header FIFO
interface buffer_rd_if;

  logic [`ACQ_ADDR_W-1:0] mem_addr;   // data memory read address
  logic [`ACQ_DATA_W-1:0] mem_data;   // word at mem_addr, one cycle later
  logic                   hdr_rd_en;  // pop one header word
  logic [`ACQ_DATA_W-1:0] hdr_data;   // word popped in the previous cycle
  logic                   hdr_empty;

  // readout sequencer
  modport reader (
    output mem_addr, hdr_rd_en,
    input  mem_data, hdr_data, hdr_empty
  );

  // data memory owner
  modport data_side (
    input  mem_addr,
    output mem_data
  );

  // header FIFO owner
  modport header_side (
    input  hdr_rd_en,
    output hdr_data, hdr_empty
  );

endinterface

//--- design/sample_capture.sv
`timescale 1ns/1ps
`include "channel_acq_defines.svh"

module sample_capture
  import channel_acq_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   arm,             // level from the master
  input  logic                   trig,
  input  logic [`ADC_PAIR_W-1:0] adc_data,        // {high sample, low sample}
  input  logic [`ACQ_LEN_W-1:0]  buffer_size,     // ring length in words
  input  logic [`ACQ_LEN_W-1:0]  post_trig_size,  // words kept after the trigger word
  output logic                   acq_done,
  output logic                   event_done,      // one cycle, starts the header
  output logic [`ACQ_ADDR_W-1:0] stop_addr,       // next write slot = oldest word
  buffer_rd_if.data_side         rd
);

  localparam int HALF_W = `ACQ_DATA_W / 2;
  localparam int EXT_W  = HALF_W - `ADC_SAMPLE_W;  // sign bits added per sample

  acq_state_t             state;
  logic [`ACQ_ADDR_W-1:0] wr_addr;
  logic [`ACQ_ADDR_W-1:0] next_addr;
  logic [`ACQ_LEN_W-1:0]  post_cnt;    // post-trigger words still to write
  logic                   wr_en;
  logic [`ACQ_DATA_W-1:0] wr_data;
  logic [`ADC_SAMPLE_W-1:0] samp_lo;
  logic [`ADC_SAMPLE_W-1:0] samp_hi;

  logic [`ACQ_DATA_W-1:0] mem [0:(1 << `ACQ_ADDR_W)-1];

  //////////////////////////////
  // sample packing
  //////////////////////////////

  assign samp_lo = adc_data[`ADC_SAMPLE_W-1:0];
  assign samp_hi = adc_data[`ADC_PAIR_W-1:`ADC_SAMPLE_W];

  // each 13-bit sample widened to 16 bits with its own sign bit
  assign wr_data = {{EXT_W{samp_hi[`ADC_SAMPLE_W-1]}}, samp_hi,
                    {EXT_W{samp_lo[`ADC_SAMPLE_W-1]}}, samp_lo};

  //////////////////////////////
  // acquisition FSM
  //////////////////////////////

  assign wr_en = (state == ACQ_ARMED) || (state == ACQ_POST_TRIG);  // one word every cycle

  // ring wraps at buffer_size, not at the memory size
  assign next_addr = ({1'b0, wr_addr} == buffer_size - 1'b1) ? '0 : wr_addr + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ACQ_IDLE;
      wr_addr    <= '0;
      post_cnt   <= '0;
      event_done <= 1'b0;
    end else begin
      event_done <= 1'b0;  // pulse by default
      case (state)
        ACQ_IDLE: begin
          if (arm) begin
            state   <= ACQ_ARMED;
            wr_addr <= '0;  // each event starts at the bottom of the ring
          end
        end
        ACQ_ARMED: begin
          wr_addr <= next_addr;
          if (!arm) begin
            state <= ACQ_IDLE;  // master gave up on this event
          end else if (trig) begin
            // this cycle's word is the trigger word
            post_cnt <= post_trig_size;
            if (post_trig_size == '0) begin
              state      <= ACQ_DONE;
              event_done <= 1'b1;
            end else begin
              state <= ACQ_POST_TRIG;
            end
          end
        end
        ACQ_POST_TRIG: begin
          wr_addr  <= next_addr;
          post_cnt <= post_cnt - 1'b1;
          if (post_cnt == {{(`ACQ_LEN_W-1){1'b0}}, 1'b1}) begin  // last word going in now
            state      <= ACQ_DONE;
            event_done <= 1'b1;
          end
        end
        ACQ_DONE: begin
          if (!arm) state <= ACQ_IDLE;  // wr_addr frozen until then
        end
        default: state <= ACQ_IDLE;
      endcase
    end
  end

  assign acq_done  = (state == ACQ_DONE);
  assign stop_addr = wr_addr;  // already advanced past the last write

  //////////////////////////////
  // data memory
  //////////////////////////////

  // write port from the FSM, registered read port for the sequencer
  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
    rd.mem_data <= mem[rd.mem_addr];
  end

  // ring must stay still from idle through the readout of a done event
  a_no_write_idle_done: assert property (
    @(posedge clk) disable iff (reset)
    (state == ACQ_DONE || (state == ACQ_IDLE && !arm)) |=> !wr_en && $stable(stop_addr)
  ) else $error("sample_capture: write outside an armed acquisition");

  // buffer_size is a live input, the FSM never resizes the ring itself
  a_addr_in_ring: assert property (
    @(posedge clk) disable iff (reset)
    wr_en |-> ({1'b0, wr_addr} < buffer_size)
  ) else $error("sample_capture: write address %0d past buffer_size", wr_addr);

endmodule

//--- design/header_builder.sv
`timescale 1ns/1ps
`include "channel_acq_defines.svh"

module header_builder
  import channel_acq_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   event_done,       // from the acquisition FSM
  input  logic                   trig_num_we,      // load initial_trig_num
  input  logic [`ACQ_ADDR_W-1:0] stop_addr,
  input  logic [15:0]            channel_num,
  input  logic [31:0]            initial_trig_num,
  input  logic [`ACQ_LEN_W-1:0]  buffer_size,
  output logic [31:0]            current_trig_num, // readback of the counter
  buffer_rd_if.header_side       rd
);

  localparam int PTR_W = $clog2(`HDR_FIFO_DEPTH);

  logic [31:0]            trig_cnt;
  logic [15:0]            hdr_chan;   // fields frozen at event_done
  logic [31:0]            hdr_trig;
  logic [`ACQ_ADDR_W-1:0] hdr_stop;
  logic [`ACQ_LEN_W-1:0]  hdr_size;
  logic                   push_on;
  hdr_word_t              push_sel;
  logic [`ACQ_DATA_W-1:0] push_word;

  logic [`ACQ_DATA_W-1:0] fifo_mem [0:`HDR_FIFO_DEPTH-1];
  logic [PTR_W:0]         wr_ptr;     // extra msb tells full from empty
  logic [PTR_W:0]         rd_ptr;
  logic                   fifo_full;
  logic                   pop;

  //////////////////////////////
  // trigger number
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset)            trig_cnt <= '0;
    else if (trig_num_we) trig_cnt <= initial_trig_num;
    else if (event_done)  trig_cnt <= trig_cnt + 1'b1;  // next event's number
  end

  assign current_trig_num = trig_cnt;

  //////////////////////////////
  // header words
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (event_done) begin
      hdr_chan <= channel_num;
      hdr_trig <= trig_cnt;   // value before the increment
      hdr_stop <= stop_addr;
      hdr_size <= buffer_size;
    end
  end

  // four pushes on the four cycles after event_done
  always_ff @(posedge clk) begin
    if (reset) begin
      push_on  <= 1'b0;
      push_sel <= HDR_ID;
    end else if (event_done) begin
      push_on  <= 1'b1;
      push_sel <= HDR_ID;
    end else if (push_on) begin
      if (push_sel == HDR_SIZE) push_on <= 1'b0;
      push_sel <= hdr_word_t'(push_sel + 1'b1);
    end
  end

  always_comb begin
    case (push_sel)
      HDR_ID:         push_word = {`HDR_MARKER, hdr_chan};
      HDR_TRIG_NUM:   push_word = hdr_trig;
      HDR_START_ADDR: push_word = {{(`ACQ_DATA_W-`ACQ_ADDR_W){1'b0}}, hdr_stop};
      default:        push_word = {{(`ACQ_DATA_W-`ACQ_LEN_W){1'b0}}, hdr_size};
    endcase
  end

  //////////////////////////////
  // header FIFO
  //////////////////////////////

  assign fifo_full    = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                        (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign rd.hdr_empty = (wr_ptr == rd_ptr);
  assign pop          = rd.hdr_rd_en && !rd.hdr_empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_on && !fifo_full) wr_ptr <= wr_ptr + 1'b1;  // word dropped when full
      if (pop)                   rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_on && !fifo_full) fifo_mem[wr_ptr[PTR_W-1:0]] <= push_word;
    if (pop)                   rd.hdr_data <= fifo_mem[rd_ptr[PTR_W-1:0]];
  end

  // master re-armed with four unread events queued
  a_no_push_full: assert property (
    @(posedge clk) disable iff (reset) push_on |-> !fifo_full
  ) else $error("header_builder: header word lost, FIFO full");

  // the sequencer checks empty only at read_start
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (reset) rd.hdr_rd_en |-> !rd.hdr_empty
  ) else $error("header_builder: pop from empty header FIFO");

endmodule

//--- design/readout_sequencer.sv
`timescale 1ns/1ps
`include "channel_acq_defines.svh"

module readout_sequencer
  import channel_acq_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   read_start,  // pulse, ignored while busy
  output logic [`ACQ_DATA_W-1:0] out_data,
  output logic                   out_valid,
  output logic                   out_last,    // final data word of the event
  buffer_rd_if.reader            rd
);

  localparam logic [`ACQ_LEN_W-1:0] ONE_WORD = 1;

  rd_state_t              state;
  hdr_word_t              phase;       // index of the word now on hdr_data
  logic [`ACQ_ADDR_W-1:0] rd_addr;
  logic [`ACQ_ADDR_W-1:0] next_addr;
  logic [`ACQ_LEN_W-1:0]  buf_len;
  logic [`ACQ_LEN_W-1:0]  cur_len;
  logic [`ACQ_LEN_W-1:0]  reads_left;  // memory reads still to issue
  logic                   hdr_fwd;
  logic                   mem_rd;
  logic                   rd_final;
  logic                   mem_vld;     // mem_data holds a word to forward
  logic                   last_d;

  //////////////////////////////
  // read issue
  //////////////////////////////

  assign hdr_fwd = (state == RD_HEADER);  // every header cycle carries a word

  // size comes straight off the FIFO on the HDR_SIZE cycle
  assign cur_len = (state == RD_DATA) ? buf_len : rd.hdr_data[`ACQ_LEN_W-1:0];

  // first memory read overlaps the size word so data follows with no gap
  assign mem_rd   = ((state == RD_HEADER) && (phase == HDR_SIZE)) || (state == RD_DATA);
  assign rd_final = mem_rd && ((state == RD_DATA) ? (reads_left == ONE_WORD)
                                                  : (cur_len == ONE_WORD));

  assign next_addr   = ({1'b0, rd_addr} == cur_len - 1'b1) ? '0 : rd_addr + 1'b1;
  assign rd.mem_addr = rd_addr;

  // first pop on read_start itself, then one per cycle up to the size word
  assign rd.hdr_rd_en = ((state == RD_IDLE) && read_start && !rd.hdr_empty) ||
                        ((state == RD_HEADER) && (phase != HDR_SIZE));

  //////////////////////////////
  // sequencer FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= RD_IDLE;
      phase      <= HDR_ID;
      rd_addr    <= '0;
      reads_left <= '0;
      mem_vld    <= 1'b0;
      last_d     <= 1'b0;
      out_valid  <= 1'b0;
      out_last   <= 1'b0;
    end else begin
      mem_vld   <= mem_rd;
      last_d    <= rd_final;
      out_valid <= hdr_fwd || mem_vld;
      out_last  <= mem_vld && last_d;
      case (state)
        RD_IDLE: begin
          if (read_start && !rd.hdr_empty) begin
            state <= RD_HEADER;
            phase <= HDR_ID;
          end
        end
        RD_HEADER: begin
          phase <= hdr_word_t'(phase + 1'b1);
          if (phase == HDR_START_ADDR) rd_addr <= rd.hdr_data[`ACQ_ADDR_W-1:0];  // oldest word
          if (phase == HDR_SIZE) begin
            rd_addr    <= next_addr;
            buf_len    <= cur_len;
            reads_left <= cur_len - 1'b1;
            state      <= (cur_len > ONE_WORD) ? RD_DATA : RD_IDLE;
          end
        end
        RD_DATA: begin
          rd_addr    <= next_addr;
          reads_left <= reads_left - 1'b1;
          if (reads_left == ONE_WORD) state <= RD_IDLE;  // last word still in flight
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  // header and data never overlap, the last memory word lands after RD_DATA
  always_ff @(posedge clk) begin
    out_data <= hdr_fwd ? rd.hdr_data : rd.mem_data;
  end

endmodule

//--- design/channel_acq_top.sv
`timescale 1ns/1ps
`include "channel_acq_defines.svh"

module channel_acq_top (
  input  logic                   clk,
  input  logic                   reset,
  // acquisition control
  input  logic                   arm,
  input  logic                   trig,
  output logic                   acq_done,
  input  logic [`ADC_PAIR_W-1:0] adc_data,         // two samples per clock
  // event configuration
  input  logic [`ACQ_LEN_W-1:0]  buffer_size,      // words per event
  input  logic [`ACQ_LEN_W-1:0]  post_trig_size,   // words after the trigger word
  input  logic [15:0]            channel_num,
  input  logic [31:0]            initial_trig_num,
  input  logic                   trig_num_we,
  output logic [31:0]            current_trig_num,
  // readout stream
  input  logic                   read_start,
  output logic [`ACQ_DATA_W-1:0] out_data,
  output logic                   out_valid,
  output logic                   out_last
);

  logic                   event_done;
  logic [`ACQ_ADDR_W-1:0] stop_addr;

  buffer_rd_if buf_rd ();  // memory and header FIFO read side

  //////////////////////////////
  // capture into the ring
  //////////////////////////////

  sample_capture u_capture (
    .clk            (clk),
    .reset          (reset),
    .arm            (arm),
    .trig           (trig),
    .adc_data       (adc_data),
    .buffer_size    (buffer_size),
    .post_trig_size (post_trig_size),
    .acq_done       (acq_done),
    .event_done     (event_done),
    .stop_addr      (stop_addr),
    .rd             (buf_rd.data_side)
  );

  header_builder u_header (
    .clk              (clk),
    .reset            (reset),
    .event_done       (event_done),
    .trig_num_we      (trig_num_we),
    .stop_addr        (stop_addr),
    .channel_num      (channel_num),
    .initial_trig_num (initial_trig_num),
    .buffer_size      (buffer_size),
    .current_trig_num (current_trig_num),
    .rd               (buf_rd.header_side)
  );

  //////////////////////////////
  // readout to the master
  //////////////////////////////

  readout_sequencer u_readout (
    .clk        (clk),
    .reset      (reset),
    .read_start (read_start),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .rd         (buf_rd.reader)
  );

endmodule

//--- verif/channel_acq_tb.sv
`timescale 1ns/1ps
`include "channel_acq_defines.svh"

module channel_acq_tb;

  localparam int NUM_EVENTS = 3;
  localparam int MAX_EXTRA  = 63;  // largest random part of the trigger delay

  logic                   clk;
  logic                   reset;
  logic                   arm;
  logic                   trig;
  logic                   acq_done;
  logic [`ADC_PAIR_W-1:0] adc_data;
  logic [`ACQ_LEN_W-1:0]  buffer_size;
  logic [`ACQ_LEN_W-1:0]  post_trig_size;
  logic [15:0]            channel_num;
  logic [31:0]            initial_trig_num;
  logic                   trig_num_we;
  logic [31:0]            current_trig_num;
  logic                   read_start;
  logic [`ACQ_DATA_W-1:0] out_data;
  logic                   out_valid;
  logic                   out_last;

  logic [31:0]              lfsr;
  logic [`ADC_SAMPLE_W-1:0] adc_lo;   // low sample for the next clock
  logic [`ADC_SAMPLE_W-1:0] trig_lo;  // low sample on the trigger cycle
  logic [`ADC_SAMPLE_W-1:0] prev_lo;
  logic [31:0]              trig_base;
  logic [31:0]              exp_trig;
  int                       exp_stop, exp_size, exp_post;
  int                       pos, valid_words, runs_done;  // stream monitor state
  int                       errors, err_mark, tests_run, tests_bad;
  string                    test_name;

  channel_acq_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // counter pattern, high sample one above the low one
  always @(negedge clk) begin
    adc_data <= {adc_lo + 13'd1, adc_lo};
    adc_lo   <= adc_lo + 13'd2;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  function automatic logic [15:0] sign_extend(input logic [12:0] s);
    return {{3{s[12]}}, s};
  endfunction

  function automatic int ev_size(input int ev);
    return (ev == 0) ? 40 : (ev == 1) ? 24 : 64;
  endfunction

  function automatic int ev_post(input int ev);
    return (ev == 0) ? 10 : (ev == 1) ? 0 : 63;  // zero and size - 1 as edge cases
  endfunction

  task automatic rand_bits(input int n, output int unsigned val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      val  = (val << 1) | lfsr[0];
    end
  endtask

  task automatic flag_error(input string msg);
    errors++;
    $display("error at time %0t: %s", $time, msg);
  endtask

  task automatic flag_timeout(input string msg);
    errors++;
    $display("timed out: %s", msg);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", test_name, errors - err_mark);
    end
  endtask

  //////////////////////////////
  // stream checks
  //////////////////////////////

  task automatic check_header(input int idx, input logic [31:0] w);
    logic [31:0] want;
    case (idx)
      0:       want = {`HDR_MARKER, channel_num};
      1:       want = exp_trig;
      2:       want = exp_stop;   // oldest word in the ring
      default: want = exp_size;
    endcase
    assert (w == want)
      else flag_error($sformatf("header word %0d is %h, expected %h", idx, w, want));
  endtask

  task automatic check_samples(input int idx, input logic [31:0] w);
    logic [12:0] lo;
    logic [12:0] hi;
    lo = w[12:0];
    hi = w[28:16];
    assert (w[15:0] == sign_extend(lo) && w[31:16] == sign_extend(hi))
      else flag_error($sformatf("data word %0d is %h, not sign-extended", idx, w));
    assert (hi == lo + 13'd1)
      else flag_error($sformatf("data word %0d is %h, high not low + 1", idx, w));
    if (idx > 0) begin  // age order, one clock per word
      assert (lo == prev_lo + 13'd2)
        else flag_error($sformatf("data word %0d low is %h, expected %h",
                                  idx, lo, prev_lo + 13'd2));
    end
    if (idx == exp_size - 1 - exp_post) begin
      assert (lo == trig_lo)
        else flag_error($sformatf("trigger word %0d low is %h, expected %h", idx, lo, trig_lo));
    end
    prev_lo = lo;
  endtask

  // sampled on the rising edge where registered outputs still hold their old value
  always @(posedge clk) begin
    if (trig) trig_lo <= adc_data[`ADC_SAMPLE_W-1:0];
    if (reset) begin
      pos = 0;
    end else if (out_valid) begin
      valid_words++;
      if (pos < `HDR_WORDS) check_header(pos, out_data);
      else check_samples(pos - `HDR_WORDS, out_data);
      if (pos == `HDR_WORDS + exp_size - 1) begin
        assert (out_last) else flag_error("out_last missing on the final word");
      end else begin
        assert (!out_last) else flag_error($sformatf("out_last on word %0d", pos));
      end
      pos++;
    end else if (pos != 0) begin  // run just ended
      assert (pos == `HDR_WORDS + exp_size)
        else flag_error($sformatf("out_valid run of %0d words, expected %0d",
                                  pos, `HDR_WORDS + exp_size));
      runs_done++;
      pos = 0;
    end
  end

  a_reset_quiet: assert property (@(posedge clk) reset |=> !acq_done && !out_valid && !out_last)
    else flag_error("acq_done, out_valid or out_last high after reset");
  a_done_holds: assert property (@(posedge clk) disable iff (reset) acq_done && arm |=> acq_done)
    else flag_error("acq_done dropped while arm was high");
  a_done_clears: assert property (@(posedge clk) disable iff (reset)
                                  acq_done && !arm |=> !acq_done)
    else flag_error("acq_done still high after arm dropped");
  a_last_valid: assert property (@(posedge clk) disable iff (reset) out_last |-> out_valid)
    else flag_error("out_last without out_valid");

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic run_event(input int ev);
    int unsigned extra;
    int          delay, cycles, runs0;
    rand_bits(6, extra);
    delay          = ev_size(ev) + int'(extra);  // ring full before the trigger
    buffer_size    = ev_size(ev);
    post_trig_size = ev_post(ev);
    exp_size       = ev_size(ev);
    exp_post       = ev_post(ev);
    exp_stop       = (delay + 1 + ev_post(ev)) % ev_size(ev);
    exp_trig       = trig_base + ev;
    arm = 1'b1;
    @(negedge clk);                 // armed, first write on the next edge
    repeat (delay) @(negedge clk);
    trig = 1'b1;
    @(negedge clk);
    trig   = 1'b0;
    cycles = 0;
    while (!acq_done && cycles <= ev_post(ev) + 10) begin
      @(negedge clk);
      cycles++;
    end
    if (!acq_done) begin
      flag_timeout("acq_done did not rise after the trigger");
    end else begin
      assert (cycles == ev_post(ev))
        else flag_error($sformatf("acq_done rose %0d cycles after trigger", cycles));
    end
    repeat (4) @(negedge clk);      // header pushes done, arm still high
    assert (current_trig_num == trig_base + ev + 1)
      else flag_error($sformatf("current_trig_num is %h", current_trig_num));
    arm = 1'b0;
    repeat (3) @(negedge clk);
    runs0      = runs_done;
    read_start = 1'b1;
    @(negedge clk);
    read_start = 1'b0;
    @(negedge clk);
    assert (out_valid) else flag_error("out_valid not high 2 cycles after read_start");
    cycles = 0;
    while (runs_done == runs0 && cycles < ev_size(ev) + 20) begin
      @(negedge clk);
      cycles++;
    end
    if (runs_done == runs0) flag_timeout("readout run never ended");
  endtask

  initial begin
    int unsigned r;
    int          words0;
    lfsr             = 32'h290692c5;
    reset            = 1'b1;
    arm              = 1'b0;
    trig             = 1'b0;
    adc_data         = '0;
    buffer_size      = 13'd40;
    post_trig_size   = '0;
    channel_num      = 16'h0017;
    initial_trig_num = '0;
    trig_num_we      = 1'b0;
    read_start       = 1'b0;
    rand_bits(7, r);
    adc_lo = 13'h0f80 + r[12:0];    // crosses the sign boundary early
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    start_test("reset");
    @(negedge clk);
    assert (!acq_done && !out_valid && !out_last) else flag_error("outputs high after reset");
    finish_test();

    start_test("trigger number load");
    rand_bits(32, r);
    initial_trig_num = r;
    trig_num_we      = 1'b1;
    @(negedge clk);
    trig_num_we = 1'b0;
    trig_base   = initial_trig_num;
    @(negedge clk);
    assert (current_trig_num == trig_base)
      else flag_error($sformatf("current_trig_num is %h after load", current_trig_num));
    finish_test();

    for (int ev = 0; ev < NUM_EVENTS; ev++) begin
      start_test($sformatf("event %0d", ev));
      run_event(ev);
      finish_test();
    end

    start_test("read with no event");
    words0     = valid_words;
    read_start = 1'b1;
    @(negedge clk);
    read_start = 1'b0;
    repeat (10) @(negedge clk);     // well past the read latency
    assert (valid_words == words0) else flag_error("output produced with no event pending");
    finish_test();

    $display("%0d tests run, %0d with errors, %0d errors", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // bound from the event sizes plus room for reset and the short tests
  initial begin
    int limit;
    limit = 300;
    for (int ev = 0; ev < NUM_EVENTS; ev++) begin
      limit += 2 * ev_size(ev) + ev_post(ev) + MAX_EXTRA + 40;
    end
    repeat (limit) @(posedge clk);
    $display("watchdog: run still going after %0d cycles", limit);
    $display("tests failed");
    $finish;
  end

endmodule

//--- channel_acq.f
+incdir+design
design/channel_acq_pkg.sv
design/buffer_rd_if.sv
design/sample_capture.sv
design/header_builder.sv
design/readout_sequencer.sv
design/channel_acq_top.sv
verif/channel_acq_tb.sv
